/* project.f */
+incdir+verilog
+incdir+test
verilog/fixed_pkg.sv
verilog/frame_pkg.sv
verilog/pixel_scanner.sv
verilog/escape_iterator.sv
verilog/palette_writer.sv
verilog/mandel_render.sv
test/tb_mandel_render.sv

/* Makefile */
# Verilator build of the Mandelbrot render testbench

VERILATOR ?= verilator
TOP ?= tb_mandel_render
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
BUILD_JOBS ?= 4
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) -j $(BUILD_JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_reference.svh */
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

//////////////////////////////////////////////////
// Reference model of the render
//////////////////////////////////////////////////

// Wrap to a signed FIXED_WIDTH-bit word
function automatic longint wrap_fixed(input longint value);
	longint modulus;
	longint low;
	modulus = longint'(1) << `FIXED_WIDTH;
	low = value & (modulus - 1);
	if (low >= (modulus >> 1)) begin
		low = low - modulus;
	end
	return low;
endfunction

// 4.23 product shifted down by the fraction bits
// Top bit of the word takes the sign of the full product
function automatic longint trunc_product(input longint a, input longint b);
	longint full;
	longint shifted;
	longint half;
	full = a * b;
	shifted = full >>> `FIXED_FRAC;
	half = longint'(1) << (`FIXED_WIDTH - 1);
	shifted = shifted & (half - 1);
	if (full < 0) begin
		shifted = shifted - half;
	end
	return shifted;
endfunction

// Escape-time count of one point, z starting at 0
function automatic int expected_count(input longint c_re, input longint c_im);
	longint two;
	longint four;
	longint zr;
	longint zi;
	longint zr_sq;
	longint zi_sq;
	longint zr_new;
	longint zi_new;
	longint zr_sq_new;
	longint zi_sq_new;
	int count;
	bit escaped;
	two = longint'(2) << `FIXED_FRAC;
	four = longint'(4) << `FIXED_FRAC;
	zr = 0;
	zi = 0;
	zr_sq = 0;
	zi_sq = 0;
	count = 0;
	escaped = 1'b0;
	while (!escaped) begin
		zr_new = wrap_fixed(zr_sq - zi_sq + c_re);
		zi_new = wrap_fixed(2 * trunc_product(zr, zi) + c_im);
		zr_sq_new = trunc_product(zr_new, zr_new);
		zi_sq_new = trunc_product(zi_new, zi_new);
		// Magnitude, either component out of range, or the last allowed step
		escaped = (zr_sq_new + zi_sq_new > four)
			|| (zr_new > two) || (zr_new < -two)
			|| (zi_new > two) || (zi_new < -two)
			|| (count == `ITER_MAX - 1);
		count = count + 1;
		zr = zr_new;
		zi = zi_new;
		zr_sq = zr_sq_new;
		zi_sq = zi_sq_new;
	end
	return count;
endfunction

// Band table, tested from the cap downwards
function automatic frame_pkg::color_t expected_color(input int count);
	frame_pkg::color_t color;
	if (count >= `ITER_MAX) begin
		color = 8'b000_000_00;
	end else if (count >= `ITER_MAX / 4) begin
		color = 8'b011_001_00;
	end else if (count >= `ITER_MAX / 8) begin
		color = 8'b101_010_01;
	end else if (count >= `ITER_MAX / 16) begin
		color = 8'b011_001_01;
	end else if (count >= `ITER_MAX / 32) begin
		color = 8'b001_001_01;
	end else begin
		color = 8'b010_100_10;
	end
	return color;
endfunction

// Colour of one frame address for a given view
function automatic frame_pkg::color_t expected_pixel_color(input longint x, input longint y,
		input longint step, input int addr);
	int col;
	int row;
	longint c_re;
	longint c_im;
	col = addr % `FRAME_WIDTH;
	row = addr / `FRAME_WIDTH;
	// Right adds the step, down subtracts it
	c_re = wrap_fixed(x + col * step);
	c_im = wrap_fixed(y - row * step);
	return expected_color(expected_count(c_re, c_im));
endfunction

`endif

/* test/tb_mandel_render.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mandel_config.svh"

module tb_mandel_render;

	`include "tb_reference.svh"

	localparam int PIXEL_COUNT = `FRAME_WIDTH * `FRAME_HEIGHT;
	localparam int NUM_TESTS = 5;

	// Worst case frame with start and done overhead
	localparam int FRAME_CYCLES = PIXEL_COUNT * (`ITER_MAX + 4);
	localparam int CYCLE_LIMIT = NUM_TESTS * FRAME_CYCLES + 2000;

	localparam longint ONE = longint'(1) << `FIXED_FRAC;

	logic clk;
	logic reset;
	logic start;
	fixed_pkg::fixed_t x_start;
	fixed_pkg::fixed_t y_start;
	fixed_pkg::fixed_t pixel_step;
	logic pix_we;
	frame_pkg::frame_addr_t pix_addr;
	frame_pkg::color_t pix_color;
	logic busy;
	logic done;

	// Captured frame
	frame_pkg::color_t captured [PIXEL_COUNT];
	bit written [PIXEL_COUNT];
	int write_count;
	int done_count;

	// Write strobe seen one cycle earlier
	bit we_prev;

	// View behind the frame under check
	longint view_x;
	longint view_y;
	longint view_step;

	int error_count;
	int test_start_errors;
	int tests_run;
	int failed_tests;
	int cycle_count;

	mandel_render i_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.pixel_step(pixel_step),
		.pix_we(pix_we),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_color(input string name, input frame_pkg::color_t got,
			input frame_pkg::color_t expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input frame_pkg::frame_addr_t got,
			input frame_pkg::frame_addr_t expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
			error_count++;
		end
	endtask

	//////////////////////////////////////////////////
	// Write monitor
	//////////////////////////////////////////////////

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (pix_we === 1'b1) begin
			// Writes go out in scan order
			check_addr("pix_addr", pix_addr, frame_pkg::frame_addr_t'(write_count));
			if (pix_addr >= PIXEL_COUNT) begin
				$display("Write to address 0x%02h lies outside the frame", pix_addr);
				error_count++;
			end else begin
				if (written[pix_addr]) begin
					$display("Address 0x%02h was written twice in one frame", pix_addr);
					error_count++;
				end
				captured[pix_addr] = pix_color;
				written[pix_addr] = 1'b1;
			end
			write_count++;
		end
		if (done === 1'b1) begin
			done_count++;
			if (write_count != PIXEL_COUNT) begin
				$display("done pulsed after %0d of %0d writes", write_count, PIXEL_COUNT);
				error_count++;
			end
			// done comes right after the last write, busy falls with it
			if (!we_prev) begin
				$display("done did not follow the last write by one cycle");
				error_count++;
			end
			check_flag("busy", busy, 1'b0);
		end
		we_prev = (pix_we === 1'b1);
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic begin_test();
		test_start_errors = error_count;
	endtask

	task automatic end_test(input string name);
		int errors;
		errors = error_count - test_start_errors;
		tests_run++;
		if (errors == 0) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d error(s)", name, errors);
			failed_tests++;
		end
	endtask

	task automatic clear_capture();
		for (int a = 0; a < PIXEL_COUNT; a++) begin
			written[a] = 1'b0;
			captured[a] = '0;
		end
		write_count = 0;
		done_count = 0;
	endtask

	// Called on a falling edge with the DUT idle
	task automatic start_render(input longint x, input longint y, input longint step);
		clear_capture();
		view_x = x;
		view_y = y;
		view_step = step;
		x_start = fixed_pkg::fixed_t'(x);
		y_start = fixed_pkg::fixed_t'(y);
		pixel_step = fixed_pkg::fixed_t'(step);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// busy rises with the first point
		check_flag("busy", busy, 1'b1);
	endtask

	task automatic wait_frame_done();
		int waited;
		waited = 0;
		while (done !== 1'b1 && waited < FRAME_CYCLES + 100) begin
			@(negedge clk);
			waited++;
		end
		if (done !== 1'b1) begin
			$display("done never pulsed within %0d cycles", waited);
			error_count++;
		end
		// Monitor takes the done cycle first
		@(negedge clk);
	endtask

	task automatic check_frame_end();
		if (write_count != PIXEL_COUNT) begin
			$display("Frame gave %0d writes instead of %0d", write_count, PIXEL_COUNT);
			error_count++;
		end
		if (done_count != 1) begin
			$display("done pulsed %0d times in one frame", done_count);
			error_count++;
		end
		check_flag("done", done, 1'b0);
		check_flag("busy", busy, 1'b0);
	endtask

	task automatic compare_frame();
		for (int a = 0; a < PIXEL_COUNT; a++) begin
			if (!written[a]) begin
				$display("Address 0x%02h was never written", a);
				error_count++;
			end else begin
				check_color($sformatf("pix_color[0x%02h]", a), captured[a],
					expected_pixel_color(view_x, view_y, view_step, a));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	// Outputs quiet after reset and with no start
	task automatic test_reset_idle();
		begin_test();
		repeat (20) begin
			check_flag("pix_we", pix_we, 1'b0);
			check_flag("done", done, 1'b0);
			check_flag("busy", busy, 1'b0);
			@(negedge clk);
		end
		end_test("reset_idle");
	endtask

	// Classic view from (-2.0, 1.0) at 5/32 per pixel
	task automatic test_classic_view();
		int capped;
		begin_test();
		capped = 0;
		start_render(-2 * ONE, ONE, ONE * 5 / 32);
		wait_frame_done();
		compare_frame();
		// Points at the cap must come out black
		for (int a = 0; a < PIXEL_COUNT; a++) begin
			if (expected_pixel_color(view_x, view_y, view_step, a) == 8'h00
					&& written[a] && captured[a] == 8'h00) begin
				capped++;
			end
		end
		if (capped == 0) begin
			$display("No pixel at the iteration cap came out black");
			error_count++;
		end
		end_test("classic_view");
	endtask

	// Write count, order and done on a zoomed view
	task automatic test_frame_sequence();
		begin_test();
		start_render(-ONE * 3 / 4, ONE / 4, ONE / 64);
		wait_frame_done();
		check_frame_end();
		compare_frame();
		end_test("frame_sequence");
	endtask

	// A second start mid-frame is ignored
	task automatic test_start_while_busy();
		int waited;
		begin_test();
		waited = 0;
		start_render(-2 * ONE, ONE, ONE * 5 / 32);
		while (write_count < PIXEL_COUNT / 4 && waited < FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		x_start = fixed_pkg::fixed_t'(ONE / 2);
		y_start = fixed_pkg::fixed_t'(-ONE / 2);
		pixel_step = fixed_pkg::fixed_t'(ONE / 16);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_flag("busy", busy, 1'b1);
		wait_frame_done();
		check_frame_end();
		compare_frame();
		// No second frame may follow
		repeat (2 * (`ITER_MAX + 4)) begin
			@(negedge clk);
		end
		if (write_count != PIXEL_COUNT || done_count != 1) begin
			$display("Ignored start led to further writes or done pulses");
			error_count++;
		end
		check_flag("busy", busy, 1'b0);
		end_test("start_while_busy");
	endtask

	// Random corner and step, captured anew on start
	task automatic test_random_view();
		longint x;
		longint y;
		longint step;
		begin_test();
		x = -ONE * 3 / 2 + longint'($urandom % 32'(2 * ONE));
		y = -ONE / 2 + longint'($urandom % 32'(ONE * 3 / 2));
		step = ONE / 128 + longint'($urandom % 32'(ONE / 32));
		start_render(x, y, step);
		wait_frame_done();
		check_frame_end();
		compare_frame();
		end_test("random_view");
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		cycle_count = 0;
		error_count = 0;
		tests_run = 0;
		failed_tests = 0;
		view_x = 0;
		view_y = 0;
		view_step = 0;
		we_prev = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		x_start = '0;
		y_start = '0;
		pixel_step = '0;
		void'($urandom(32'h12b2));
		clear_capture();
		// Three rising edges in reset, release on the next falling edge
		repeat (3) begin
			@(posedge clk);
		end
		@(negedge clk);
		reset = 1'b0;

		test_reset_idle();
		test_classic_view();
		test_frame_sequence();
		test_start_while_busy();
		test_random_view();

		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, failed_tests, error_count);
		if (error_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/mandel_render.sv */
`timescale 1ns/100ps
`default_nettype none

module mandel_render (
	input logic clk,
	input logic reset,
	input logic start,
	input fixed_pkg::fixed_t x_start,
	input fixed_pkg::fixed_t y_start,
	input fixed_pkg::fixed_t pixel_step,
	output logic pix_we,
	output frame_pkg::frame_addr_t pix_addr,
	output frame_pkg::color_t pix_color,
	output logic busy,
	output logic done
);

	// Scanner to iterator
	logic point_valid;
	fixed_pkg::fixed_t point_c_re;
	fixed_pkg::fixed_t point_c_im;

	// Iterator to scanner and writer
	logic result_valid;
	fixed_pkg::iter_count_t result_count;

	// Writer back to scanner
	logic frame_done;

	pixel_scanner i_pixel_scanner (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.pixel_step(pixel_step),
		.result_valid(result_valid),
		.frame_done(frame_done),
		.point_valid(point_valid),
		.point_c_re(point_c_re),
		.point_c_im(point_c_im),
		.busy(busy)
	);

	escape_iterator i_escape_iterator (
		.clk(clk),
		.reset(reset),
		.point_valid(point_valid),
		.point_c_re(point_c_re),
		.point_c_im(point_c_im),
		.result_valid(result_valid),
		.result_count(result_count)
	);

	palette_writer i_palette_writer (
		.clk(clk),
		.reset(reset),
		.result_valid(result_valid),
		.result_count(result_count),
		.pix_we(pix_we),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.frame_done(frame_done)
	);

	assign done = frame_done;

endmodule

`default_nettype wire

/* verilog/palette_writer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mandel_config.svh"

module palette_writer (
	input logic clk,
	input logic reset,
	input logic result_valid,
	input fixed_pkg::iter_count_t result_count,
	output logic pix_we,
	output frame_pkg::frame_addr_t pix_addr,
	output frame_pkg::color_t pix_color,
	output logic frame_done
);

	localparam frame_pkg::frame_addr_t LAST_ADDR =
		frame_pkg::frame_addr_t'(frame_pkg::PIXEL_COUNT - 1);

	// Address of the next write
	frame_pkg::frame_addr_t addr_cnt;

	// Band table tested from the cap downwards
	function automatic frame_pkg::color_t band_color(input fixed_pkg::iter_count_t count);
		frame_pkg::color_t color;
		if (count >= `ITER_MAX) begin
			color = frame_pkg::COLOR_BLACK;
		end else if (count >= (`ITER_MAX / 4)) begin
			// Upper half and second quarter share one shade
			color = frame_pkg::COLOR_HIGH;
		end else if (count >= (`ITER_MAX / 8)) begin
			color = frame_pkg::COLOR_MID;
		end else if (count >= (`ITER_MAX / 16)) begin
			color = frame_pkg::COLOR_LOW;
		end else if (count >= (`ITER_MAX / 32)) begin
			color = frame_pkg::COLOR_FAINT;
		end else begin
			color = frame_pkg::COLOR_OUTSIDE;
		end
		return color;
	endfunction

	//////////////////////////////////////////////////
	// Write strobe and frame end
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_we <= 1'b0;
			frame_done <= 1'b0;
			addr_cnt <= '0;
		end else begin
			pix_we <= result_valid;
			// One cycle after the write to the last address
			frame_done <= pix_we && (pix_addr == LAST_ADDR);
			if (result_valid) begin
				if (addr_cnt == LAST_ADDR) begin
					addr_cnt <= '0;
				end else begin
					addr_cnt <= addr_cnt + 1'b1;
				end
			end
		end
	end

	// Write payload
	always_ff @(posedge clk) begin
		if (result_valid) begin
			pix_addr <= addr_cnt;
			pix_color <= band_color(result_count);
		end
	end

endmodule

`default_nettype wire

/* verilog/escape_iterator.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mandel_config.svh"

module escape_iterator (
	input logic clk,
	input logic reset,
	input logic point_valid,
	input fixed_pkg::fixed_t point_c_re,
	input fixed_pkg::fixed_t point_c_im,
	output logic result_valid,
	output fixed_pkg::iter_count_t result_count
);

	typedef enum logic {
		IDLE,
		ITER
	} state_t;

	state_t state;

	// Point and current z
	fixed_pkg::fixed_t c_re;
	fixed_pkg::fixed_t c_im;
	fixed_pkg::fixed_t zr;
	fixed_pkg::fixed_t zi;

	// Squares of the current z
	fixed_pkg::fixed_t zr_sq;
	fixed_pkg::fixed_t zi_sq;

	// Next z and its squares
	fixed_pkg::fixed_t zr_zi;
	fixed_pkg::fixed_t zr_next;
	fixed_pkg::fixed_t zi_next;
	fixed_pkg::fixed_t zr_sq_next;
	fixed_pkg::fixed_t zi_sq_next;

	// One extra bit so that 4 + 4 does not wrap
	logic signed [`FIXED_WIDTH:0] mag_sq;

	fixed_pkg::iter_count_t count;
	logic escape;

	// Truncating 4.23 product
	function automatic fixed_pkg::fixed_t fx_mul(
		input fixed_pkg::fixed_t a,
		input fixed_pkg::fixed_t b
	);
		logic signed [2*`FIXED_WIDTH-1:0] full;
		full = a * b;
		// Sign bit plus the integer and fraction bits of the result
		return {full[2*`FIXED_WIDTH-1], full[`FIXED_WIDTH+`FIXED_FRAC-2:`FIXED_FRAC]};
	endfunction

	//////////////////////////////////////////////////
	// z <- z^2 + c
	//////////////////////////////////////////////////

	assign zr_zi = fx_mul(zr, zi);
	assign zr_next = zr_sq - zi_sq + c_re;
	assign zi_next = (zr_zi <<< 1) + c_im;

	// Squares of the new z feed both the test and the next step
	assign zr_sq_next = fx_mul(zr_next, zr_next);
	assign zi_sq_next = fx_mul(zi_next, zi_next);
	assign mag_sq = zr_sq_next + zi_sq_next;

	// Escape on the new z or on the last allowed step
	assign escape = (mag_sq > fixed_pkg::FIXED_FOUR)
		|| (zr_next > fixed_pkg::FIXED_TWO)
		|| (zr_next < -fixed_pkg::FIXED_TWO)
		|| (zi_next > fixed_pkg::FIXED_TWO)
		|| (zi_next < -fixed_pkg::FIXED_TWO)
		|| (count == fixed_pkg::iter_count_t'(`ITER_MAX - 1));

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (point_valid) begin
						state <= ITER;
					end
				end
				ITER: begin
					if (escape) begin
						state <= IDLE;
						result_valid <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			if (point_valid) begin
				// Load c and start from z = 0
				c_re <= point_c_re;
				c_im <= point_c_im;
				zr <= '0;
				zi <= '0;
				zr_sq <= '0;
				zi_sq <= '0;
				count <= '0;
			end
		end else begin
			zr <= zr_next;
			zi <= zi_next;
			zr_sq <= zr_sq_next;
			zi_sq <= zi_sq_next;
			count <= count + 1'b1;
		end
	end

	// Count stays put while idle
	assign result_count = count;

endmodule

`default_nettype wire

/* verilog/pixel_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mandel_config.svh"

module pixel_scanner (
	input logic clk,
	input logic reset,
	input logic start,
	input fixed_pkg::fixed_t x_start,
	input fixed_pkg::fixed_t y_start,
	input fixed_pkg::fixed_t pixel_step,
	input logic result_valid,
	input logic frame_done,
	output logic point_valid,
	output fixed_pkg::fixed_t point_c_re,
	output fixed_pkg::fixed_t point_c_im,
	output logic busy
);

	// Captured view
	fixed_pkg::fixed_t x_base;
	fixed_pkg::fixed_t step;

	// Position of the point in flight
	frame_pkg::pixel_x_t col;
	frame_pkg::pixel_y_t row;

	logic busy_reg;
	logic start_ok;
	logic row_end;
	logic last_pixel;

	assign start_ok = start && !busy;
	assign row_end = (col == frame_pkg::pixel_x_t'(`FRAME_WIDTH - 1));
	assign last_pixel = row_end && (row == frame_pkg::pixel_y_t'(`FRAME_HEIGHT - 1));

	// Drops in the same cycle as the done pulse
	assign busy = busy_reg && !frame_done;

	//////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			point_valid <= 1'b0;
			busy_reg <= 1'b0;
			col <= '0;
			row <= '0;
		end else begin
			point_valid <= 1'b0;
			if (start_ok) begin
				// First point goes out next cycle
				point_valid <= 1'b1;
				busy_reg <= 1'b1;
				col <= '0;
				row <= '0;
			end else begin
				if (result_valid) begin
					// Hold off after the final pixel
					point_valid <= !last_pixel;
					if (row_end) begin
						col <= '0;
						row <= row + 1'b1;
					end else begin
						col <= col + 1'b1;
					end
				end
				if (frame_done) begin
					busy_reg <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Point stepping
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start_ok) begin
			x_base <= x_start;
			step <= pixel_step;
			point_c_re <= x_start;
			point_c_im <= y_start;
		end else if (result_valid) begin
			if (row_end) begin
				// Back to the left edge and one row down
				point_c_re <= x_base;
				point_c_im <= point_c_im - step;
			end else begin
				point_c_re <= point_c_re + step;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_pkg.sv */
`default_nettype none

`include "mandel_config.svh"

package frame_pkg;

	localparam int PIXEL_COUNT = `FRAME_WIDTH * `FRAME_HEIGHT;

	// Pixel position in the frame
	typedef logic [$clog2(`FRAME_WIDTH)-1:0] pixel_x_t;
	typedef logic [$clog2(`FRAME_HEIGHT)-1:0] pixel_y_t;

	// Row * FRAME_WIDTH + column
	typedef logic [$clog2(PIXEL_COUNT)-1:0] frame_addr_t;

	// 3-3-2 red green blue
	typedef logic [7:0] color_t;

	// Palette bands from the cap downwards
	localparam color_t COLOR_BLACK = 8'b000_000_00;
	localparam color_t COLOR_HIGH = 8'b011_001_00;
	localparam color_t COLOR_MID = 8'b101_010_01;
	localparam color_t COLOR_LOW = 8'b011_001_01;
	localparam color_t COLOR_FAINT = 8'b001_001_01;
	localparam color_t COLOR_OUTSIDE = 8'b010_100_10;

endpackage

`default_nettype wire

/* verilog/fixed_pkg.sv */
`default_nettype none

`include "mandel_config.svh"

package fixed_pkg;

	// Signed 4.23 value for points and z terms
	typedef logic signed [`FIXED_WIDTH-1:0] fixed_t;

	// Holds 0 up to ITER_MAX inclusive
	typedef logic [$clog2(`ITER_MAX+1)-1:0] iter_count_t;

	// Component bound of the escape test
	localparam fixed_t FIXED_TWO = fixed_t'(2 * (1 << `FIXED_FRAC));

	// Bound on the squared magnitude
	localparam fixed_t FIXED_FOUR = fixed_t'(4 * (1 << `FIXED_FRAC));

endpackage

`default_nettype wire

/* verilog/mandel_config.svh */
`ifndef MANDEL_CONFIG_SVH
`define MANDEL_CONFIG_SVH

//////////////////////////////////////////////////
// Frame geometry
//////////////////////////////////////////////////

// Pixels per row
`define FRAME_WIDTH 16

// Rows per frame
`define FRAME_HEIGHT 12

//////////////////////////////////////////////////
// Iteration and number format
//////////////////////////////////////////////////

// Iteration limit for points that never escape
`define ITER_MAX 64

// Signed 4.23 fixed point
`define FIXED_WIDTH 27
`define FIXED_FRAC 23

`endif
